// ==== rtl/cnn_fas_pkg.sv ====
package cnn_fas_pkg;

    //////////////////////////////
    // Pipeline latencies
    //////////////////////////////

    // Map FIFO read latency in cycles
    localparam int FAS_FIFO_LATENCY = 2;
    // Vector adder latency in cycles
    localparam int VEC_ADD_LATENCY  = 3;
    // Second residual add waits on two FIFO reads plus one add
    localparam int RM1_DELAY        = 2 * FAS_FIFO_LATENCY + VEC_ADD_LATENCY;

    // Strobes sharing the short delay line
    localparam int NUM_DELAYED      = 5;

    //////////////////////////////
    // Opcode bit indices
    //////////////////////////////

    localparam int NUM_OPCODES = 18;

    localparam int OPC_0  = 0;
    localparam int OPC_1  = 1;
    localparam int OPC_2  = 2;
    localparam int OPC_3  = 3;
    localparam int OPC_4  = 4;
    localparam int OPC_5  = 5;
    localparam int OPC_6  = 6;
    localparam int OPC_7  = 7;
    localparam int OPC_8  = 8;
    localparam int OPC_9  = 9;
    localparam int OPC_10 = 10;
    localparam int OPC_11 = 11;
    localparam int OPC_12 = 12;
    localparam int OPC_13 = 13;
    localparam int OPC_14 = 14;
    localparam int OPC_15 = 15;
    // Reserved, no layer operation behind it
    localparam int OPC_16 = 16;
    localparam int OPC_17 = 17;

    // One-hot layer operation select
    typedef logic [NUM_OPCODES-1:0] opcode_cfg_t;
    // Kernel counter from the sequencer
    typedef logic [15:0]            krnl_count_t;

    // Sequencer state, one-hot
    typedef enum logic [7:0] {
        IDLE            = 8'b0000_0001,
        LD_1X1_KRN      = 8'b0000_0010,
        LD_1X1_KRB      = 8'b0000_0100,
        CFG_AWP         = 8'b0000_1000,
        START_AWP       = 8'b0001_0000,
        ACTIVE          = 8'b0010_0000,
        WAIT_LAST_WRITE = 8'b0100_0000,
        SEND_COMPLETE   = 8'b1000_0000
    } fas_state_t;

endpackage

// ==== rtl/fas_bit_delay.sv ====
`timescale 1ns/1ps

module fas_bit_delay #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk_FAS,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    //////////////////////////////
    // Shift stages
    //////////////////////////////

    // Stage 0 takes din, last stage drives dout
    logic [WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge clk_FAS or negedge arst_n) begin
        if (!arst_n) begin
            // Strobes must not leak out of reset
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            // Advance one stage per cycle
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Total delay is DEPTH cycles from din to dout
    assign dout = stage_q[DEPTH-1];

endmodule

// ==== rtl/fas_issue_ctrl.sv ====
`timescale 1ns/1ps

module fas_issue_ctrl (
    input  logic                     clk_FAS,
    input  logic                     arst_n,
    input  logic                     fas_rdy_n,
    input  cnn_fas_pkg::opcode_cfg_t opcode_cfg,
    input  cnn_fas_pkg::fas_state_t  state,
    input  logic                     conv_map_empty,
    input  logic                     part_map_empty,
    input  logic                     resd_map_empty,
    input  logic                     prev_map_empty,
    input  cnn_fas_pkg::krnl_count_t krnl_count,
    input  logic                     dwc_fifo_rden,
    input  logic                     pipe_enable,
    output logic                     issue,
    output logic                     add_pm,
    output logic                     add_rm0,
    output logic                     add_rm1,
    output logic                     add_rm_conv,
    output logic                     add_pv,
    output logic                     conv1x1_pip_start0,
    output logic                     conv1x1_pip_start1,
    output logic                     conv1x1_pip_start2,
    output logic                     out_buf_wren1,
    output logic                     out_buf_wren2
);

    import cnn_fas_pkg::*;

    // Common issue qualifier
    logic issue_ok;
    logic part_rdy;
    logic resd_rdy;
    logic prev_rdy;
    logic krnl_zero;

    // Next-cycle strobe values
    logic issue_d;
    logic add_pm_d;
    logic add_rm0_d;
    logic add_rm1_d;
    logic start0_d;
    logic start1_d;
    logic start2_d;
    logic wren1_d;
    logic wren2_d;

    // Depthwise read decode
    logic dwc_rm_conv_hit;
    logic dwc_pv_hit;

    //////////////////////////////
    // Issue decision
    //////////////////////////////

    // Only ACTIVE and WAIT_LAST_WRITE may issue, and never over a step in flight
    assign issue_ok  = (state == ACTIVE || state == WAIT_LAST_WRITE)
                       && !pipe_enable && !conv_map_empty;
    assign part_rdy  = !part_map_empty;
    assign resd_rdy  = !resd_map_empty;
    assign prev_rdy  = !prev_map_empty;
    assign krnl_zero = (krnl_count == '0);

    // First matching rule from OPC_0 upward wins
    always_comb begin
        issue_d   = 1'b0;
        add_pm_d  = 1'b0;
        add_rm0_d = 1'b0;
        add_rm1_d = 1'b0;
        start0_d  = 1'b0;
        start1_d  = 1'b0;
        start2_d  = 1'b0;
        wren1_d   = 1'b0;
        wren2_d   = 1'b0;
        if (issue_ok) begin
            if (opcode_cfg[OPC_0] && part_rdy && resd_rdy) begin
                issue_d  = 1'b1;
                start1_d = 1'b1;
                add_pm_d = krnl_zero;
            end else if ((opcode_cfg[OPC_1] || opcode_cfg[OPC_11]) && part_rdy && prev_rdy) begin
                issue_d  = 1'b1;
                start1_d = 1'b1;
                add_pm_d = krnl_zero;
            end else if (opcode_cfg[OPC_2] || opcode_cfg[OPC_12] || opcode_cfg[OPC_14]) begin
                // Convolution map alone
                issue_d  = 1'b1;
                start0_d = 1'b1;
            end else if ((opcode_cfg[OPC_3] || opcode_cfg[OPC_13]) && prev_rdy) begin
                issue_d  = 1'b1;
                start0_d = 1'b1;
            end else if (opcode_cfg[OPC_4] && part_rdy && resd_rdy) begin
                issue_d   = 1'b1;
                start2_d  = 1'b1;
                add_pm_d  = krnl_zero;
                add_rm1_d = krnl_zero;
            end else if (opcode_cfg[OPC_5] && part_rdy && resd_rdy && prev_rdy) begin
                issue_d   = 1'b1;
                start2_d  = 1'b1;
                add_pm_d  = krnl_zero;
                add_rm1_d = krnl_zero;
            end else if (opcode_cfg[OPC_6] && resd_rdy) begin
                // Writes through buffer 2 on every step
                issue_d   = 1'b1;
                start1_d  = 1'b1;
                wren2_d   = 1'b1;
                add_rm0_d = krnl_zero;
            end else if (opcode_cfg[OPC_7] && resd_rdy && prev_rdy) begin
                issue_d   = 1'b1;
                start1_d  = 1'b1;
                add_rm0_d = krnl_zero;
            end else if (opcode_cfg[OPC_8] && part_rdy && resd_rdy) begin
                issue_d   = 1'b1;
                add_pm_d  = 1'b1;
                add_rm1_d = 1'b1;
                wren2_d   = 1'b1;
            end else if ((opcode_cfg[OPC_9] || opcode_cfg[OPC_17]) && resd_rdy) begin
                issue_d   = 1'b1;
                add_rm0_d = 1'b1;
                wren1_d   = 1'b1;
            end else if (opcode_cfg[OPC_10] && part_rdy) begin
                issue_d  = 1'b1;
                add_pm_d = 1'b1;
                start1_d = 1'b1;
            end else if (opcode_cfg[OPC_15] && part_rdy) begin
                issue_d  = 1'b1;
                add_pm_d = 1'b1;
                wren1_d  = 1'b1;
            end
        end
    end

    // One-cycle strobes, held low while the stage is not ready
    always_ff @(posedge clk_FAS or negedge arst_n) begin
        if (!arst_n) begin
            issue              <= 1'b0;
            add_pm             <= 1'b0;
            add_rm0            <= 1'b0;
            add_rm1            <= 1'b0;
            conv1x1_pip_start0 <= 1'b0;
            conv1x1_pip_start1 <= 1'b0;
            conv1x1_pip_start2 <= 1'b0;
            out_buf_wren1      <= 1'b0;
            out_buf_wren2      <= 1'b0;
        end else if (fas_rdy_n) begin
            issue              <= 1'b0;
            add_pm             <= 1'b0;
            add_rm0            <= 1'b0;
            add_rm1            <= 1'b0;
            conv1x1_pip_start0 <= 1'b0;
            conv1x1_pip_start1 <= 1'b0;
            conv1x1_pip_start2 <= 1'b0;
            out_buf_wren1      <= 1'b0;
            out_buf_wren2      <= 1'b0;
        end else begin
            issue              <= issue_d;
            add_pm             <= add_pm_d;
            add_rm0            <= add_rm0_d;
            add_rm1            <= add_rm1_d;
            conv1x1_pip_start0 <= start0_d;
            conv1x1_pip_start1 <= start1_d;
            conv1x1_pip_start2 <= start2_d;
            out_buf_wren1      <= wren1_d;
            out_buf_wren2      <= wren2_d;
        end
    end

    //////////////////////////////
    // Depthwise add strobes
    //////////////////////////////

    // Independent of sequencer state
    assign dwc_rm_conv_hit = dwc_fifo_rden && (opcode_cfg[OPC_0] || opcode_cfg[OPC_2]);
    assign dwc_pv_hit      = dwc_fifo_rden && (opcode_cfg[OPC_1] || opcode_cfg[OPC_3]
                                               || opcode_cfg[OPC_5] || opcode_cfg[OPC_7]);

    always_ff @(posedge clk_FAS or negedge arst_n) begin
        if (!arst_n) begin
            add_rm_conv <= 1'b0;
            add_pv      <= 1'b0;
        end else if (fas_rdy_n) begin
            add_rm_conv <= 1'b0;
            add_pv      <= 1'b0;
        end else begin
            add_rm_conv <= dwc_rm_conv_hit;
            add_pv      <= dwc_pv_hit;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // One pipeline entry per step
    a_start_onehot0: assert property (@(posedge clk_FAS) disable iff (!arst_n)
        $onehot0({conv1x1_pip_start0, conv1x1_pip_start1, conv1x1_pip_start2}));

    // Output buffers are written one at a time
    a_wren_excl: assert property (@(posedge clk_FAS) disable iff (!arst_n)
        !(out_buf_wren1 && out_buf_wren2));

    // Sequencer selects a single layer operation
    a_opcode_onehot0: assert property (@(posedge clk_FAS) disable iff (!arst_n)
        $onehot0(opcode_cfg));

endmodule

// ==== rtl/cnn_fas_pip_ctrl.sv ====
`timescale 1ns/1ps

module cnn_fas_pip_ctrl (
    input  logic                     clk_FAS,
    input  logic                     arst_n,
    input  logic                     fas_rdy_n,
    input  cnn_fas_pkg::opcode_cfg_t opcode_cfg,
    input  cnn_fas_pkg::fas_state_t  state,
    input  logic                     conv_map_empty,
    input  logic                     part_map_empty,
    input  logic                     resd_map_empty,
    input  logic                     prev_map_empty,
    input  cnn_fas_pkg::krnl_count_t krnl_count,
    input  logic                     dwc_fifo_rden,
    output logic                     pipe_enable,
    output logic                     conv1x1_pip_start0,
    output logic                     conv1x1_pip_start1,
    output logic                     conv1x1_pip_start2,
    output logic                     vector_add_pm,
    output logic                     vector_add_rm0,
    output logic                     vector_add_rm1,
    output logic                     vector_add_rm_conv,
    output logic                     vector_add_pv,
    output logic                     out_buf_wren1,
    output logic                     out_buf_wren2
);

    import cnn_fas_pkg::*;

    // Strobes ahead of the delay lines
    logic issue;
    logic add_pm;
    logic add_rm0;
    logic add_rm1;
    logic add_rm_conv;
    logic add_pv;

    //////////////////////////////
    // Issue decision
    //////////////////////////////

    // pipe_enable comes back as the in-flight block
    fas_issue_ctrl i_issue_ctrl (
        .clk_FAS            (clk_FAS),
        .arst_n             (arst_n),
        .fas_rdy_n          (fas_rdy_n),
        .opcode_cfg         (opcode_cfg),
        .state              (state),
        .conv_map_empty     (conv_map_empty),
        .part_map_empty     (part_map_empty),
        .resd_map_empty     (resd_map_empty),
        .prev_map_empty     (prev_map_empty),
        .krnl_count         (krnl_count),
        .dwc_fifo_rden      (dwc_fifo_rden),
        .pipe_enable        (pipe_enable),
        .issue              (issue),
        .add_pm             (add_pm),
        .add_rm0            (add_rm0),
        .add_rm1            (add_rm1),
        .add_rm_conv        (add_rm_conv),
        .add_pv             (add_pv),
        .conv1x1_pip_start0 (conv1x1_pip_start0),
        .conv1x1_pip_start1 (conv1x1_pip_start1),
        .conv1x1_pip_start2 (conv1x1_pip_start2),
        .out_buf_wren1      (out_buf_wren1),
        .out_buf_wren2      (out_buf_wren2)
    );

    //////////////////////////////
    // Latency matching
    //////////////////////////////

    // Align with map FIFO read data
    fas_bit_delay #(
        .WIDTH (NUM_DELAYED),
        .DEPTH (FAS_FIFO_LATENCY)
    ) i_short_delay (
        .clk_FAS (clk_FAS),
        .arst_n  (arst_n),
        .din     ({issue, add_pm, add_rm0, add_rm_conv, add_pv}),
        .dout    ({pipe_enable, vector_add_pm, vector_add_rm0,
                   vector_add_rm_conv, vector_add_pv})
    );

    // Second residual add lands after the first add result
    fas_bit_delay #(
        .WIDTH (1),
        .DEPTH (RM1_DELAY)
    ) i_long_delay (
        .clk_FAS (clk_FAS),
        .arst_n  (arst_n),
        .din     (add_rm1),
        .dout    (vector_add_rm1)
    );

endmodule

// ==== dv/tb_cnn_fas_pip_ctrl.sv ====
`timescale 1ns/1ps

module tb_cnn_fas_pip_ctrl;

    import cnn_fas_pkg::*;

    // Golden file layout, six words per case
    localparam int NUM_FIELDS   = 6;
    localparam int MAX_CASES    = 64;
    // Long enough to watch the long delay line drain
    localparam int CHECK_CYCLES = RM1_DELAY + 3;
    localparam int QUIET_LIMIT  = 32;
    // Edges from an issue to the edge it blocks
    localparam int BLOCK_GAP    = 1 + FAS_FIFO_LATENCY;
    localparam int SHORT_LAT    = 1 + FAS_FIFO_LATENCY;
    localparam int LONG_LAT     = 1 + RM1_DELAY;

    logic        clk_FAS = 1'b0;
    logic        arst_n;
    logic        fas_rdy_n;
    opcode_cfg_t opcode_cfg;
    fas_state_t  state;
    logic        conv_map_empty;
    logic        part_map_empty;
    logic        resd_map_empty;
    logic        prev_map_empty;
    krnl_count_t krnl_count;
    logic        dwc_fifo_rden;

    logic pipe_enable;
    logic conv1x1_pip_start0;
    logic conv1x1_pip_start1;
    logic conv1x1_pip_start2;
    logic vector_add_pm;
    logic vector_add_rm0;
    logic vector_add_rm1;
    logic vector_add_rm_conv;
    logic vector_add_pv;
    logic out_buf_wren1;
    logic out_buf_wren2;

    // Output bit 0 is out_buf_wren2, bit 10 is pipe_enable
    string out_names [11] = '{"out_buf_wren2", "out_buf_wren1", "vector_add_pv",
                              "vector_add_rm_conv", "vector_add_rm1", "vector_add_rm0",
                              "vector_add_pm", "conv1x1_pip_start2", "conv1x1_pip_start1",
                              "conv1x1_pip_start0", "pipe_enable"};
    int    out_lat [11]   = '{1, 1, SHORT_LAT, SHORT_LAT, LONG_LAT, SHORT_LAT, SHORT_LAT,
                              1, 1, 1, SHORT_LAT};

    logic [15:0] golden_mem [NUM_FIELDS*MAX_CASES];
    int          n_cases;
    integer      seed;

    always #10 clk_FAS = ~clk_FAS;

    cnn_fas_pip_ctrl i_cnn_fas_pip_ctrl (
        .clk_FAS            (clk_FAS),
        .arst_n             (arst_n),
        .fas_rdy_n          (fas_rdy_n),
        .opcode_cfg         (opcode_cfg),
        .state              (state),
        .conv_map_empty     (conv_map_empty),
        .part_map_empty     (part_map_empty),
        .resd_map_empty     (resd_map_empty),
        .prev_map_empty     (prev_map_empty),
        .krnl_count         (krnl_count),
        .dwc_fifo_rden      (dwc_fifo_rden),
        .pipe_enable        (pipe_enable),
        .conv1x1_pip_start0 (conv1x1_pip_start0),
        .conv1x1_pip_start1 (conv1x1_pip_start1),
        .conv1x1_pip_start2 (conv1x1_pip_start2),
        .vector_add_pm      (vector_add_pm),
        .vector_add_rm0     (vector_add_rm0),
        .vector_add_rm1     (vector_add_rm1),
        .vector_add_rm_conv (vector_add_rm_conv),
        .vector_add_pv      (vector_add_pv),
        .out_buf_wren1      (out_buf_wren1),
        .out_buf_wren2      (out_buf_wren2)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Outputs in top-level port order
    function automatic logic [10:0] sample_outputs();
        return {pipe_enable, conv1x1_pip_start0, conv1x1_pip_start1, conv1x1_pip_start2,
                vector_add_pm, vector_add_rm0, vector_add_rm1, vector_add_rm_conv,
                vector_add_pv, out_buf_wren1, out_buf_wren2};
    endfunction

    task automatic check_value(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %0b, expected %0b", $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs(input logic [10:0] expected);
        logic [10:0] act;
        act = sample_outputs();
        for (int b = 0; b < 11; b++) begin
            check_value(out_names[b], act[b], expected[b]);
        end
    endtask

    // Sequencer back in IDLE, FIFOs drained
    task automatic drive_idle();
        opcode_cfg     <= '0;
        state          <= IDLE;
        conv_map_empty <= 1'b1;
        part_map_empty <= 1'b1;
        resd_map_empty <= 1'b1;
        prev_map_empty <= 1'b1;
        krnl_count     <= '0;
        dwc_fifo_rden  <= 1'b0;
        fas_rdy_n      <= 1'b0;
    endtask

    // Bounded wait for all strobes to drain
    task automatic wait_outputs_low();
        int n;
        n = 0;
        @(negedge clk_FAS);
        while (sample_outputs() != '0) begin
            if (n == QUIET_LIMIT) begin
                $display("** Error at %0t: outputs did not return low after a case", $time);
                $display("Test FAILED");
                $fatal(1, "drain timeout");
            end
            n++;
            @(negedge clk_FAS);
        end
        @(posedge clk_FAS);
    endtask

    //////////////////////////////
    // Golden cases
    //////////////////////////////

    task automatic run_case(input int idx);
        logic [15:0] opc_idx;
        logic [15:0] st_code;
        logic [15:0] empty_bits;
        logic [15:0] krnl_zero;
        logic [15:0] dwc_rden;
        logic [15:0] mask;
        logic [31:0] krnl_rand;
        logic [10:0] exp_now;
        opc_idx    = golden_mem[idx*NUM_FIELDS];
        st_code    = golden_mem[idx*NUM_FIELDS + 1];
        empty_bits = golden_mem[idx*NUM_FIELDS + 2];
        krnl_zero  = golden_mem[idx*NUM_FIELDS + 3];
        dwc_rden   = golden_mem[idx*NUM_FIELDS + 4];
        mask       = golden_mem[idx*NUM_FIELDS + 5];
        krnl_rand  = $random(seed);
        // Sampled at the next edge, the decision edge
        opcode_cfg     <= opcode_cfg_t'(1) << opc_idx;
        state          <= fas_state_t'(st_code[7:0]);
        conv_map_empty <= empty_bits[3];
        part_map_empty <= empty_bits[2];
        resd_map_empty <= empty_bits[1];
        prev_map_empty <= empty_bits[0];
        krnl_count     <= krnl_zero[0] ? '0 : (krnl_rand[15:0] | 16'h0001);
        dwc_fifo_rden  <= dwc_rden[0];
        @(posedge clk_FAS);
        drive_idle();
        // Each strobe only at its own latency
        for (int c = 1; c <= CHECK_CYCLES; c++) begin
            @(negedge clk_FAS);
            for (int b = 0; b < 11; b++) begin
                exp_now[b] = mask[b] && (c == out_lat[b]);
            end
            check_outputs(exp_now);
            @(posedge clk_FAS);
        end
    endtask

    //////////////////////////////
    // Held-ready runs
    //////////////////////////////

    // OPC_2 held ready, fas_rdy_n high on edges rdy_first..rdy_last
    task automatic run_held(input int n_edges, input int rdy_first, input int rdy_last);
        logic issued [32];
        logic rdy_n_at;
        logic exp_pe;
        for (int j = 0; j < 32; j++) begin
            issued[j] = 1'b0;
        end
        // Issue unless one from BLOCK_GAP edges earlier is on pipe_enable
        for (int j = 1; j <= n_edges; j++) begin
            rdy_n_at  = (j >= rdy_first) && (j <= rdy_last);
            issued[j] = !rdy_n_at && !((j > BLOCK_GAP) ? issued[j-BLOCK_GAP] : 1'b0);
        end
        opcode_cfg     <= opcode_cfg_t'(1) << OPC_2;
        state          <= ACTIVE;
        conv_map_empty <= 1'b0;
        fas_rdy_n      <= (rdy_first <= 1) && (rdy_last >= 1);
        for (int j = 1; j <= n_edges; j++) begin
            @(posedge clk_FAS);
            if (j == n_edges) begin
                drive_idle();
            end else begin
                fas_rdy_n <= (j + 1 >= rdy_first) && (j + 1 <= rdy_last);
            end
            @(negedge clk_FAS);
            check_value("conv1x1_pip_start0", conv1x1_pip_start0, issued[j]);
            exp_pe = (j > FAS_FIFO_LATENCY) ? issued[j-FAS_FIFO_LATENCY] : 1'b0;
            check_value("pipe_enable", pipe_enable, exp_pe);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        seed    = 32'hc022;
        n_cases = 0;
        // FIFO ready but sequencer IDLE through reset
        arst_n         = 1'b0;
        fas_rdy_n      = 1'b0;
        opcode_cfg     = opcode_cfg_t'(1) << OPC_2;
        state          = IDLE;
        conv_map_empty = 1'b0;
        part_map_empty = 1'b0;
        resd_map_empty = 1'b0;
        prev_map_empty = 1'b0;
        krnl_count     = '0;
        dwc_fifo_rden  = 1'b0;
        $readmemh("dv/cnn_fas_pip_ctrl_golden.txt", golden_mem);
        while (n_cases < MAX_CASES && !$isunknown(golden_mem[n_cases*NUM_FIELDS])) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("** Error: the golden file holds no test cases");
            $display("Test FAILED");
            $fatal(1, "no stimulus");
        end
        // Three edges under reset
        repeat (2) begin
            @(negedge clk_FAS);
            check_outputs('0);
        end
        @(posedge clk_FAS);
        arst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk_FAS);
            check_outputs('0);
            @(posedge clk_FAS);
        end
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
            wait_outputs_low();
        end
        // Blocking pattern, then ready clear mid-run
        run_held(12, 1, 0);
        wait_outputs_low();
        run_held(16, 6, 10);
        wait_outputs_low();
        $display("Test OK");
        $finish;
    end

endmodule

// ==== cnn_fas_pip_ctrl.f ====
rtl/cnn_fas_pkg.sv
rtl/fas_bit_delay.sv
rtl/fas_issue_ctrl.sv
rtl/cnn_fas_pip_ctrl.sv
dv/tb_cnn_fas_pip_ctrl.sv

// ==== Bender.yml ====
package:
  name: cnn_fas_pip_ctrl

sources:
  - rtl/cnn_fas_pkg.sv
  - rtl/fas_bit_delay.sv
  - rtl/fas_issue_ctrl.sv
  - rtl/cnn_fas_pip_ctrl.sv
  - target: test
    files:
      - dv/tb_cnn_fas_pip_ctrl.sv

// ==== dv/cnn_fas_pip_ctrl_golden.txt ====
// opcode_idx state_code empty(conv,part,resd,prev) krnl_zero dwc_rden expected_mask
// mask bits 10..0: pipe_enable start0 start1 start2 pm rm0 rm1 rm_conv pv wren1 wren2
00 20 0 1 0 540
00 40 0 0 0 500
01 20 0 1 0 540
0b 40 0 0 0 500
02 20 0 0 0 600
0c 40 0 1 0 600
0e 20 0 0 0 600
03 20 0 1 0 600
0d 20 0 0 0 600
04 20 0 1 0 4d0
04 40 0 0 0 480
05 20 0 1 0 4d0
06 20 0 1 0 521
06 20 0 0 0 501
07 40 0 1 0 520
08 20 0 0 0 451
09 20 0 1 0 422
11 40 0 0 0 422
0a 20 0 0 0 540
0f 20 0 1 0 442
00 20 4 1 0 000
02 20 8 0 0 000
05 20 1 1 0 000
06 20 2 1 0 000
02 01 0 0 0 000
00 80 0 1 0 000
00 01 f 0 1 008
02 80 f 0 1 008
01 01 f 0 1 004
05 01 f 0 1 004
07 40 f 0 1 004
02 20 0 0 1 608
